// File: all.f
+incdir+logic
logic/backend_pkg.sv
logic/ctrl_pkg.sv
logic/mem_stage.sv
logic/wb_sequencer.sv
logic/reg_file.sv
logic/csr_file.sv
logic/backend_top.sv
verification/backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard logic/*.sv logic/*.svh verification/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_defs.svh"

module backend_tb;

    localparam int LATENCY        = `BACKEND_MEM_LATENCY;
    localparam int FINISH_TIMEOUT = LATENCY + 20;
    localparam int MEM_WORDS      = 2 ** `BACKEND_MEM_ADDR_W;

    // one table entry with its expected results
    typedef struct {
        backend_pkg::instr_t    instr;
        int                     offset;
        backend_pkg::commit_t   exp_commit;
        backend_pkg::reg_addr_t chk_reg;
        backend_pkg::word_t     exp_reg;
        backend_pkg::csr_sel_t  chk_csr;
        backend_pkg::word_t     exp_csr;
    } row_t;

    logic                   clock;
    logic                   reset;
    logic                   issue_valid;
    backend_pkg::instr_t    issue_instr;
    backend_pkg::commit_t   commit;
    logic                   finish;
    backend_pkg::reg_addr_t rf_raddr;
    backend_pkg::word_t     rf_rdata;
    backend_pkg::csr_sel_t  csr_rsel;
    backend_pkg::word_t     csr_rdata;

    // reference model of the architectural state
    backend_pkg::word_t model_regs [`BACKEND_REG_COUNT];
    backend_pkg::word_t model_csrs [8];
    backend_pkg::word_t model_mem [MEM_WORDS];

    row_t rows [$];
    int   error_count;
    int   check_count;
    logic timed_out;

    backend_top DUT (
        .clock_i       (clock),
        .reset_i       (reset),
        .issue_valid_i (issue_valid),
        .issue_instr_i (issue_instr),
        .commit_o      (commit),
        .finish_o      (finish),
        .rf_raddr_i    (rf_raddr),
        .rf_rdata_o    (rf_rdata),
        .csr_rsel_i    (csr_rsel),
        .csr_rdata_o   (csr_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // data words come from the seeded generator
    function automatic backend_pkg::instr_t make_instr(
        input logic wd, input backend_pkg::reg_addr_t rd, input logic is_mem,
        input logic is_store, input backend_pkg::mem_addr_t addr,
        input backend_pkg::csr_sel_t sel);
        backend_pkg::instr_t instr;
        instr            = '0;
        instr.wd         = wd;
        instr.rd         = rd;
        instr.alu_result = $urandom();
        instr.is_mem     = is_mem;
        instr.is_store   = is_store;
        instr.mem_addr   = addr;
        instr.store_data = $urandom();
        instr.csr_sel    = sel;
        instr.csr_wdata  = $urandom();
        return instr;
    endfunction

    task automatic add_row(input backend_pkg::instr_t instr,
                           input backend_pkg::reg_addr_t chk_reg,
                           input backend_pkg::csr_sel_t chk_csr);
        row_t               row;
        backend_pkg::word_t wdata;
        if (instr.is_mem && !instr.is_store) begin
            wdata = model_mem[instr.mem_addr];
        end else begin
            wdata = instr.alu_result;
        end
        row.instr                = instr;
        row.offset               = instr.is_mem ? LATENCY : 1;
        row.exp_commit.wd        = instr.wd;
        row.exp_commit.wreg      = instr.rd;
        row.exp_commit.wdata     = wdata;
        row.exp_commit.csr_sel   = instr.csr_sel;
        row.exp_commit.csr_wdata = instr.csr_wdata;
        // apply the commit to the model
        if (instr.is_mem && instr.is_store) begin
            model_mem[instr.mem_addr] = instr.store_data;
        end
        if (instr.wd && instr.rd != '0) begin
            model_regs[instr.rd] = wdata;
        end
        if (instr.csr_sel != backend_pkg::CSR_NONE) begin
            model_csrs[instr.csr_sel] = instr.csr_wdata;
        end
        row.chk_reg = chk_reg;
        row.exp_reg = model_regs[chk_reg];
        row.chk_csr = chk_csr;
        row.exp_csr = model_csrs[chk_csr];
        rows.push_back(row);
    endtask

    task automatic build_table();
        for (int i = 0; i < `BACKEND_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            model_csrs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        // alu write, x0 write, wd clear
        add_row(make_instr(1'b1, 5'd5, 1'b0, 1'b0, 6'd0, backend_pkg::CSR_NONE),
                5'd5, backend_pkg::CSR_NONE);
        add_row(make_instr(1'b1, 5'd0, 1'b0, 1'b0, 6'd0, backend_pkg::CSR_NONE),
                5'd0, backend_pkg::CSR_NONE);
        add_row(make_instr(1'b0, 5'd6, 1'b0, 1'b0, 6'd0, backend_pkg::CSR_NONE),
                5'd6, backend_pkg::CSR_NONE);
        // store then load back
        add_row(make_instr(1'b0, 5'd0, 1'b1, 1'b1, 6'd10, backend_pkg::CSR_NONE),
                5'd7, backend_pkg::CSR_NONE);
        add_row(make_instr(1'b1, 5'd7, 1'b1, 1'b0, 6'd10, backend_pkg::CSR_NONE),
                5'd7, backend_pkg::CSR_NONE);
        // unwritten word clears a live register
        add_row(make_instr(1'b1, 5'd8, 1'b0, 1'b0, 6'd0, backend_pkg::CSR_NONE),
                5'd8, backend_pkg::CSR_NONE);
        add_row(make_instr(1'b1, 5'd8, 1'b1, 1'b0, 6'd20, backend_pkg::CSR_NONE),
                5'd8, backend_pkg::CSR_NONE);
        // overwrite then reload
        add_row(make_instr(1'b0, 5'd0, 1'b1, 1'b1, 6'd10, backend_pkg::CSR_NONE),
                5'd9, backend_pkg::CSR_NONE);
        add_row(make_instr(1'b1, 5'd9, 1'b1, 1'b0, 6'd10, backend_pkg::CSR_NONE),
                5'd9, backend_pkg::CSR_NONE);
        for (int s = 1; s <= 5; s++) begin
            add_row(make_instr(1'b0, 5'd0, 1'b0, 1'b0, 6'd0, backend_pkg::csr_sel_t'(3'(s))),
                    5'd0, backend_pkg::csr_sel_t'(3'(s)));
        end
        add_row(make_instr(1'b0, 5'd0, 1'b0, 1'b0, 6'd0, backend_pkg::CSR_NONE),
                5'd0, backend_pkg::CSR_MSTATUS);
    endtask

    task automatic run_row(input int idx);
        row_t row;
        int   k;
        logic seen;
        row  = rows[idx];
        k    = 0;
        seen = 1'b0;
        @(posedge clock);
        #1;
        issue_valid = 1'b1;
        issue_instr = row.instr;
        rf_raddr    = row.chk_reg;
        csr_rsel    = row.chk_csr;
        @(negedge clock);
        check_value($sformatf("row %0d commit in issue cycle", idx), 128'(commit), 128'(0));
        check_value($sformatf("row %0d finish in issue cycle", idx), 128'(finish), 128'(0));
        while (!seen && k < FINISH_TIMEOUT) begin
            @(posedge clock);
            #1;
            issue_valid = 1'b0;
            k++;
            @(negedge clock);
            if (k == row.offset) begin
                check_value($sformatf("row %0d commit", idx), 128'(commit),
                            128'(row.exp_commit));
            end else begin
                check_value($sformatf("row %0d idle commit", idx), 128'(commit), 128'(0));
            end
            if (finish) begin
                check_value($sformatf("row %0d finish cycle", idx), 128'(k),
                            128'(row.offset + 1));
                seen = 1'b1;
            end
        end
        if (!seen) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: no finish pulse within %0d cycles on row %0d",
                     FINISH_TIMEOUT, idx);
        end else begin
            check_value($sformatf("row %0d register", idx), 128'(rf_rdata), 128'(row.exp_reg));
            check_value($sformatf("row %0d csr", idx), 128'(csr_rdata), 128'(row.exp_csr));
        end
    endtask

    // reset while a load is still in flight
    task automatic check_reset();
        @(posedge clock);
        #1;
        issue_valid = 1'b1;
        issue_instr = make_instr(1'b1, 5'd3, 1'b1, 1'b0, 6'd10, backend_pkg::CSR_MSCRATCH);
        @(posedge clock);
        #1;
        issue_valid = 1'b0;
        reset       = 1'b1;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("finish after reset", 128'(finish), 128'(0));
        check_value("commit after reset", 128'(commit), 128'(0));
        for (int i = 0; i < `BACKEND_REG_COUNT; i++) begin
            @(posedge clock);
            #1;
            rf_raddr = backend_pkg::reg_addr_t'(i);
            csr_rsel = backend_pkg::csr_sel_t'(3'(i));
            @(negedge clock);
            check_value($sformatf("x%0d after reset", i), 128'(rf_rdata), 128'(0));
            check_value($sformatf("csr %0d after reset", i % 8), 128'(csr_rdata), 128'(0));
        end
    endtask

    initial begin
        void'($urandom(32'h47ff));
        error_count = 0;
        check_count = 0;
        timed_out   = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_instr = '0;
        rf_raddr    = '0;
        csr_rsel    = backend_pkg::CSR_NONE;
        build_table();
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            run_row(i);
        end
        if (!timed_out) begin
            check_reset();
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  logic                   issue_valid_i,
    input  backend_pkg::instr_t    issue_instr_i,
    output backend_pkg::commit_t   commit_o,
    output logic                   finish_o,
    input  backend_pkg::reg_addr_t rf_raddr_i,
    output backend_pkg::word_t     rf_rdata_o,
    input  backend_pkg::csr_sel_t  csr_rsel_i,
    output backend_pkg::word_t     csr_rdata_o
);

    backend_pkg::instr_t  held;
    backend_pkg::word_t   wb_data;
    logic                 lsu_valid;
    backend_pkg::commit_t commit;

    // holds the instruction and runs the memory access
    mem_stage u_mem_stage (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_instr_i (issue_instr_i),
        .held_o        (held),
        .wb_data_o     (wb_data),
        .lsu_valid_o   (lsu_valid)
    );

    wb_sequencer u_wb_sequencer (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .held_i        (held),
        .wb_data_i     (wb_data),
        .lsu_valid_i   (lsu_valid),
        .commit_o      (commit),
        .finish_o      (finish_o)
    );

    // architectural state, both written by the same commit
    reg_file u_reg_file (
        .clock_i  (clock_i),
        .reset_i  (reset_i),
        .commit_i (commit),
        .raddr_i  (rf_raddr_i),
        .rdata_o  (rf_rdata_o)
    );

    csr_file u_csr_file (
        .clock_i  (clock_i),
        .reset_i  (reset_i),
        .commit_i (commit),
        .rsel_i   (csr_rsel_i),
        .rdata_o  (csr_rdata_o)
    );

    assign commit_o = commit;

endmodule

`default_nettype wire

// File: logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                  clock_i,
    input  logic                  reset_i,
    input  backend_pkg::commit_t  commit_i,
    input  backend_pkg::csr_sel_t rsel_i,
    output backend_pkg::word_t    rdata_o
);

    backend_pkg::word_t mstatus_q;
    backend_pkg::word_t mtvec_q;
    backend_pkg::word_t mepc_q;
    backend_pkg::word_t mcause_q;
    backend_pkg::word_t mscratch_q;

    // whole-word write to the selected csr
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else begin
            case (commit_i.csr_sel)
                backend_pkg::CSR_MSTATUS:  mstatus_q  <= commit_i.csr_wdata;
                backend_pkg::CSR_MTVEC:    mtvec_q    <= commit_i.csr_wdata;
                backend_pkg::CSR_MEPC:     mepc_q     <= commit_i.csr_wdata;
                backend_pkg::CSR_MCAUSE:   mcause_q   <= commit_i.csr_wdata;
                backend_pkg::CSR_MSCRATCH: mscratch_q <= commit_i.csr_wdata;
                default: begin
                end
            endcase
        end
    end

    // read mux, none and unused codes give zero
    always_comb begin
        case (rsel_i)
            backend_pkg::CSR_MSTATUS:  rdata_o = mstatus_q;
            backend_pkg::CSR_MTVEC:    rdata_o = mtvec_q;
            backend_pkg::CSR_MEPC:     rdata_o = mepc_q;
            backend_pkg::CSR_MCAUSE:   rdata_o = mcause_q;
            backend_pkg::CSR_MSCRATCH: rdata_o = mscratch_q;
            default:                   rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_defs.svh"

module reg_file (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  backend_pkg::commit_t   commit_i,
    input  backend_pkg::reg_addr_t raddr_i,
    output backend_pkg::word_t     rdata_o
);

    backend_pkg::word_t regs_q [`BACKEND_REG_COUNT];

    logic we;

    // x0 is never written
    assign we = commit_i.wd && (commit_i.wreg != '0);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < `BACKEND_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we) begin
            regs_q[commit_i.wreg] <= commit_i.wdata;
        end
    end

    // observation port
    always_comb begin
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs_q[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: logic/wb_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sequencer (
    input  logic                 clock_i,
    input  logic                 reset_i,
    input  logic                 issue_valid_i,
    input  backend_pkg::instr_t  held_i,
    input  backend_pkg::word_t   wb_data_i,
    input  logic                 lsu_valid_i,
    output backend_pkg::commit_t commit_o,
    output logic                 finish_o
);

    ctrl_pkg::wb_state_t state_q;
    ctrl_pkg::wb_state_t state_d;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= ctrl_pkg::WB_WAIT_ISSUE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ctrl_pkg::WB_WAIT_ISSUE: begin
                if (issue_valid_i) begin
                    state_d = ctrl_pkg::WB_WAIT_CTRL;
                end
            end
            ctrl_pkg::WB_WAIT_CTRL: begin
                // held instruction is valid from here on
                if (held_i.is_mem) begin
                    state_d = ctrl_pkg::WB_WAIT_MEM;
                end else begin
                    state_d = ctrl_pkg::WB_COMMIT;
                end
            end
            ctrl_pkg::WB_WAIT_MEM: begin
                if (lsu_valid_i) begin
                    state_d = ctrl_pkg::WB_COMMIT;
                end
            end
            ctrl_pkg::WB_COMMIT: begin
                // finish cycle already takes the next issue
                if (issue_valid_i) begin
                    state_d = ctrl_pkg::WB_WAIT_CTRL;
                end else begin
                    state_d = ctrl_pkg::WB_WAIT_ISSUE;
                end
            end
            default: begin
                state_d = ctrl_pkg::WB_WAIT_ISSUE;
            end
        endcase
    end

    // finish trails the commit cycle by one
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            finish_o <= 1'b0;
        end else begin
            finish_o <= (state_d == ctrl_pkg::WB_COMMIT);
        end
    end

    // commit is zero outside the cycle heading into commit
    always_comb begin
        commit_o = '0;
        if (state_d == ctrl_pkg::WB_COMMIT) begin
            commit_o.wd        = held_i.wd;
            commit_o.wreg      = held_i.rd;
            commit_o.wdata     = wb_data_i;
            commit_o.csr_sel   = held_i.csr_sel;
            commit_o.csr_wdata = held_i.csr_wdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_defs.svh"

module mem_stage (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic                issue_valid_i,
    input  backend_pkg::instr_t issue_instr_i,
    output backend_pkg::instr_t held_o,
    output backend_pkg::word_t  wb_data_o,
    output logic                lsu_valid_o
);

    localparam int MEM_WORDS = 2 ** `BACKEND_MEM_ADDR_W;
    localparam int CNT_W     = $clog2(`BACKEND_MEM_LATENCY);

    ctrl_pkg::mem_state_t state_q;
    logic [CNT_W-1:0]     cnt_q;
    backend_pkg::instr_t  held_q;
    backend_pkg::word_t   load_q;
    backend_pkg::word_t   mem_q [MEM_WORDS];

    logic is_load;

    assign is_load = held_q.is_mem && !held_q.is_store;

    // done in the cycle the countdown reaches zero
    assign lsu_valid_o = (state_q == ctrl_pkg::MEM_BUSY) && (cnt_q == '0);

    // instruction register, refreshed on every issue
    always_ff @(posedge clock_i) begin
        if (issue_valid_i) begin
            held_q <= issue_instr_i;
        end
    end

    // access control
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= ctrl_pkg::MEM_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ctrl_pkg::MEM_IDLE: begin
                    if (issue_valid_i && issue_instr_i.is_mem) begin
                        state_q <= ctrl_pkg::MEM_BUSY;
                        cnt_q   <= CNT_W'(`BACKEND_MEM_LATENCY - 1);
                    end
                end
                ctrl_pkg::MEM_BUSY: begin
                    if (cnt_q == '0) begin
                        state_q <= ctrl_pkg::MEM_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= ctrl_pkg::MEM_IDLE;
                end
            endcase
        end
    end

    // data memory, cleared on reset so unwritten words read as zero
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (lsu_valid_o && held_q.is_store) begin
            mem_q[held_q.mem_addr] <= held_q.store_data;
        end
    end

    // load word sampled one cycle early so it is ready with the done pulse
    always_ff @(posedge clock_i) begin
        if (state_q == ctrl_pkg::MEM_BUSY && cnt_q == CNT_W'(1) && is_load) begin
            load_q <= mem_q[held_q.mem_addr];
        end
    end

    assign held_o    = held_q;
    assign wb_data_o = is_load ? load_q : held_q.alu_result;

endmodule

`default_nettype wire

// File: logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // writeback sequencer states
    typedef enum logic [1:0] {
        WB_WAIT_ISSUE = 2'd0,
        WB_WAIT_CTRL  = 2'd1,
        WB_WAIT_MEM   = 2'd2,
        WB_COMMIT     = 2'd3
    } wb_state_t;

    // memory stage states
    typedef enum logic {
        MEM_IDLE = 1'b0,
        MEM_BUSY = 1'b1
    } mem_state_t;

endpackage

`default_nettype wire

// File: logic/backend_pkg.sv
`default_nettype none

`include "backend_defs.svh"

package backend_pkg;

    typedef logic [`BACKEND_DATA_LEN-1:0]   word_t;
    typedef logic [`BACKEND_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`BACKEND_MEM_ADDR_W-1:0] mem_addr_t;

    // csr target of a retiring instruction
    typedef enum logic [2:0] {
        CSR_NONE     = 3'd0,
        CSR_MSTATUS  = 3'd1,
        CSR_MTVEC    = 3'd2,
        CSR_MEPC     = 3'd3,
        CSR_MCAUSE   = 3'd4,
        CSR_MSCRATCH = 3'd5
    } csr_sel_t;

    // decoded and executed instruction waiting to retire
    typedef struct packed {
        logic      wd;
        reg_addr_t rd;
        word_t     alu_result;
        logic      is_mem;
        logic      is_store;
        mem_addr_t mem_addr;
        word_t     store_data;
        csr_sel_t  csr_sel;
        word_t     csr_wdata;
    } instr_t;

    // one writeback into the architectural state
    typedef struct packed {
        logic      wd;
        reg_addr_t wreg;
        word_t     wdata;
        csr_sel_t  csr_sel;
        word_t     csr_wdata;
    } commit_t;

endpackage

`default_nettype wire

// File: logic/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// width of one data word
`define BACKEND_DATA_LEN 32

// integer register file
`define BACKEND_REG_ADDR_W 5
`define BACKEND_REG_COUNT 32

// data memory, word addressed
`define BACKEND_MEM_ADDR_W 6

// cycles from issue to the lsu done pulse, must be at least 2
`define BACKEND_MEM_LATENCY 3

`endif
